// ==== hw/camera_config.svh ====
`ifndef CAMERA_CONFIG_SVH
`define CAMERA_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~
// camera capture constants
// ~~~~~~~~~~~~~~~~~~~~

// custom-instruction number of the camera.
`define CAM_CI_ID 8'd7

// words per bus burst.
`define BURST_WORDS 8

// fifo holds 2**FIFO_DEPTH_LOG2 entries.
`define FIFO_DEPTH_LOG2 5

// top bit of the counter releases the reset.
`define RESET_COUNT_BITS 5

`endif

// ==== hw/cameraPkg.sv ====
`include "camera_config.svh"

package cameraPkg;

  typedef logic [31:0] busWord_t;
  typedef logic [7:0] pixelByte_t;
  typedef logic [7:0] burstSize_t;
  typedef logic [3:0] byteEnable_t;
  typedef logic [7:0] ciId_t;
  typedef logic [`FIFO_DEPTH_LOG2:0] fifoCount_t;

  // camera pins.
  typedef struct packed {
    logic       pclk;
    logic       hsync;
    logic       vsync;
    pixelByte_t data;
  } camIn_t;

  typedef struct packed {
    logic     frameStart;
    busWord_t pixels;
  } fifoEntry_t;

  // master side of the shared address/data bus.
  typedef struct packed {
    logic        beginTransaction;
    logic        endTransaction;
    logic        dataValid;
    logic        readNotWrite;
    byteEnable_t byteEnables;
    burstSize_t  burstSize;
    busWord_t    addressData;
  } busMasterOut_t;

  typedef struct packed {
    logic     start;
    ciId_t    n;
    busWord_t valueA;
    busWord_t valueB;
  } ciReq_t;

  typedef enum logic [2:0] {
    writeIdle,
    writeRequest,
    writeAddress,
    writeData,
    writeFinish
  } writerState_t;

endpackage

// ==== hw/pixelPacker.sv ====
`timescale 1ns/1ns

module pixelPacker import cameraPkg::*; (
  input  logic       s_systemClock,
  input  logic       reset,
  input  camIn_t     cam,
  output logic       push,
  output fifoEntry_t entry,
  output logic       frameBegin
);

  camIn_t camMeta;
  camIn_t camSync;
  logic pclkLast;
  logic vsyncLast;
  logic byteStrobe;
  logic wordDone;
  logic frameArmed;
  logic [1:0] byteCount;
  logic [23:0] partialWord;

  // ~~~~~~~~~~~~~~~~~~~~
  // pin synchronizer and edge detect
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge s_systemClock or negedge reset) begin
    if (!reset) begin
      camMeta <= '0;
      camSync <= '0;
      pclkLast <= 1'b0;
      vsyncLast <= 1'b0;
    end else begin
      camMeta <= cam;
      camSync <= camMeta;
      pclkLast <= camSync.pclk;
      vsyncLast <= camSync.vsync;
    end
  end

  assign frameBegin = camSync.vsync && !vsyncLast;
  // pclk edge only counts inside an active line.
  assign byteStrobe = camSync.pclk && !pclkLast && camSync.hsync;
  assign wordDone = byteStrobe && !frameBegin && (byteCount == 2'd3);

  // ~~~~~~~~~~~~~~~~~~~~
  // byte packing
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge s_systemClock or negedge reset) begin
    if (!reset) begin
      byteCount <= 2'd0;
      frameArmed <= 1'b0;
      push <= 1'b0;
    end else begin
      push <= wordDone;
      if (frameBegin) begin
        byteCount <= 2'd0;
        frameArmed <= 1'b1;
      end else if (byteStrobe) begin
        byteCount <= byteCount + 2'd1;
        if (wordDone) begin
          frameArmed <= 1'b0;
        end
      end
    end
  end

  // first byte of a word ends up in 31:24.
  always_ff @(posedge s_systemClock) begin
    if (byteStrobe) begin
      partialWord <= {partialWord[15:0], camSync.data};
    end
    if (wordDone) begin
      entry.pixels <= {partialWord, camSync.data};
      entry.frameStart <= frameArmed;
    end
  end

endmodule

// ==== hw/pixelFifo.sv ====
`timescale 1ns/1ns
`include "camera_config.svh"

module pixelFifo import cameraPkg::*; (
  input  logic       s_systemClock,
  input  logic       reset,
  input  logic       push,
  input  fifoEntry_t entry,
  input  logic       pop,
  output fifoEntry_t head,
  output fifoCount_t count,
  output logic       full
);

  localparam int fifoDepth = 1 << `FIFO_DEPTH_LOG2;

  typedef logic [`FIFO_DEPTH_LOG2-1:0] fifoPtr_t;

  fifoEntry_t store [fifoDepth];
  fifoPtr_t writePtr;
  fifoPtr_t readPtr;
  logic empty;
  logic doPush;
  logic doPop;

  assign full = (count == fifoCount_t'(fifoDepth));
  assign empty = (count == '0);
  assign doPush = push && !full;
  assign doPop = pop && !empty;
  assign head = store[readPtr];

  always_ff @(posedge s_systemClock) begin
    if (doPush) begin
      store[writePtr] <= entry;
    end
  end

  // pointers wrap on their own.
  always_ff @(posedge s_systemClock or negedge reset) begin
    if (!reset) begin
      writePtr <= '0;
      readPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        writePtr <= writePtr + 1'b1;
      end
      if (doPop) begin
        readPtr <= readPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // packer has no back-pressure, so a full fifo loses pixels.
  assert property (@(posedge s_systemClock) disable iff (!reset) push |-> !full)
    else $error("pixel fifo overflow, word dropped");

  assert property (@(posedge s_systemClock) disable iff (!reset) pop |-> !empty)
    else $error("pop from empty pixel fifo");

endmodule

// ==== hw/burstWriter.sv ====
`timescale 1ns/1ns
`include "camera_config.svh"

module burstWriter import cameraPkg::*; (
  input  logic          s_systemClock,
  input  logic          reset,
  input  busWord_t      baseAddress,
  input  fifoEntry_t    head,
  input  fifoCount_t    count,
  output logic          pop,
  output logic          requestBus,
  input  logic          busGrant,
  input  logic          busy,
  input  logic          busError,
  output busMasterOut_t bus
);

  localparam int beatBits = $clog2(`BURST_WORDS) + 1;
  localparam logic [beatBits-1:0] lastBeat = beatBits'(`BURST_WORDS - 1);
  localparam logic [beatBits-1:0] allBeats = beatBits'(`BURST_WORDS);
  localparam busWord_t burstBytes = busWord_t'(`BURST_WORDS * 4);

  writerState_t state;
  writerState_t nextState;
  logic [beatBits-1:0] beatCount;
  busWord_t writePointer;
  logic endBeat;
  logic beatTaken;
  logic finishing;

  assign beatTaken = (state == writeData) && !busy && !busError;
  assign finishing = (nextState == writeFinish) && (state != writeFinish);

  // ~~~~~~~~~~~~~~~~~~~~
  // state machine
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    nextState = state;
    case (state)
      writeIdle:
        if (count >= fifoCount_t'(`BURST_WORDS)) begin
          nextState = writeRequest;
        end
      writeRequest:
        if (busGrant) begin
          nextState = writeAddress;
        end
      writeAddress:
        nextState = busError ? writeFinish : writeData;
      writeData:
        if (busError || (beatTaken && beatCount == lastBeat)) begin
          nextState = writeFinish;
        end
      // stay here until an aborted burst is drained.
      writeFinish:
        if (beatCount == allBeats) begin
          nextState = writeIdle;
        end
      default:
        nextState = writeIdle;
    endcase
  end

  assign pop = beatTaken || ((state == writeFinish) && (beatCount != allBeats));
  assign requestBus = (state == writeRequest) || (state == writeAddress) ||
                      (state == writeData);

  always_ff @(posedge s_systemClock or negedge reset) begin
    if (!reset) begin
      state <= writeIdle;
      beatCount <= '0;
      writePointer <= '0;
      endBeat <= 1'b0;
    end else begin
      state <= nextState;
      endBeat <= finishing;
      if (state == writeRequest) begin
        beatCount <= '0;
      end else if (pop) begin
        beatCount <= beatCount + 1'b1;
      end
      // a frame always restarts at the base address.
      if (state == writeIdle && nextState == writeRequest && head.frameStart) begin
        writePointer <= baseAddress;
      end else if (finishing) begin
        writePointer <= writePointer + burstBytes;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // bus outputs
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    bus = '0;
    bus.endTransaction = endBeat;
    case (state)
      writeAddress: begin
        bus.beginTransaction = 1'b1;
        bus.byteEnables = '1;
        bus.burstSize = burstSize_t'(`BURST_WORDS - 1);
        bus.addressData = writePointer;
      end
      writeData: begin
        bus.dataValid = 1'b1;
        bus.addressData = head.pixels;
      end
      default: ;
    endcase
  end

  assert property (@(posedge s_systemClock) disable iff (!reset)
    bus.beginTransaction |-> $past(busGrant && state == writeRequest))
    else $error("beginTransaction without a preceding grant");

  // a stalled beat keeps its word on the bus.
  assert property (@(posedge s_systemClock) disable iff (!reset)
    bus.dataValid && busy && !busError |=> bus.dataValid && $stable(bus.addressData))
    else $error("data beat changed while busy");

endmodule

// ==== hw/cameraCapture.sv ====
`timescale 1ns/1ns
`include "camera_config.svh"

module cameraCapture import cameraPkg::*; (
  input  logic        s_systemClock,
  input  logic        s_pllLocked,
  input  logic        camPclk,
  input  logic        camHsync,
  input  logic        camVsync,
  input  pixelByte_t  camData,
  output logic        camnReset,
  input  logic        ciStart,
  input  ciId_t       ciN,
  input  busWord_t    ciValueA,
  input  busWord_t    ciValueB,
  output logic        ciDone,
  output busWord_t    ciResult,
  output logic        requestBus,
  input  logic        busGrant,
  input  logic        busy,
  input  logic        busError,
  output logic        beginTransaction,
  output logic        endTransaction,
  output logic        dataValid,
  output logic        readNotWrite,
  output byteEnable_t byteEnables,
  output burstSize_t  burstSize,
  output busWord_t    addressData
);

  logic [`RESET_COUNT_BITS-1:0] resetCount;
  logic coreReady;
  camIn_t cam;
  ciReq_t ci;
  logic ciHit;
  busWord_t baseAddress;
  busWord_t frameCount;
  logic frameBegin;
  logic push;
  logic pop;
  logic full;
  fifoEntry_t pushEntry;
  fifoEntry_t head;
  fifoCount_t count;
  busMasterOut_t busOut;

  // ~~~~~~~~~~~~~~~~~~~~
  // power-up reset
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[`RESET_COUNT_BITS-1]) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  // low while the core is held in reset.
  assign coreReady = resetCount[`RESET_COUNT_BITS-1];
  assign camnReset = coreReady;

  // ~~~~~~~~~~~~~~~~~~~~
  // custom instruction
  // ~~~~~~~~~~~~~~~~~~~~
  assign ci = '{start: ciStart, n: ciN, valueA: ciValueA, valueB: ciValueB};
  assign ciHit = coreReady && ci.start && (ci.n == `CAM_CI_ID);
  assign ciDone = ciHit;
  // result is or-ed with other units, so zero unless selected.
  assign ciResult = (ciHit && !ci.valueB[0]) ? frameCount : '0;

  always_ff @(posedge s_systemClock or negedge coreReady) begin
    if (!coreReady) begin
      baseAddress <= '0;
      frameCount <= '0;
    end else begin
      if (ciHit && ci.valueB[0]) begin
        baseAddress <= ci.valueA;
      end
      if (frameBegin) begin
        frameCount <= frameCount + 1'b1;
      end
    end
  end

  assign cam = '{pclk: camPclk, hsync: camHsync, vsync: camVsync, data: camData};

  pixelPacker packer (
    .s_systemClock(s_systemClock),
    .reset(coreReady),
    .cam(cam),
    .push(push),
    .entry(pushEntry),
    .frameBegin(frameBegin)
  );

  pixelFifo fifo (
    .s_systemClock(s_systemClock),
    .reset(coreReady),
    .push(push),
    .entry(pushEntry),
    .pop(pop),
    .head(head),
    .count(count),
    .full(full)
  );

  burstWriter writer (
    .s_systemClock(s_systemClock),
    .reset(coreReady),
    .baseAddress(baseAddress),
    .head(head),
    .count(count),
    .pop(pop),
    .requestBus(requestBus),
    .busGrant(busGrant),
    .busy(busy),
    .busError(busError),
    .bus(busOut)
  );

  assign beginTransaction = busOut.beginTransaction;
  assign endTransaction = busOut.endTransaction;
  assign dataValid = busOut.dataValid;
  assign readNotWrite = busOut.readNotWrite;
  assign byteEnables = busOut.byteEnables;
  assign burstSize = busOut.burstSize;
  assign addressData = busOut.addressData;

  // the writer must drain bursts faster than the camera fills.
  assert property (@(posedge s_systemClock) disable iff (!coreReady) full |-> !push)
    else $error("camera word lost on a full fifo");

endmodule

// ==== bench/cameraCaptureTb.sv ====
`timescale 1ns/1ns
`include "camera_config.svh"

module cameraCaptureTb import cameraPkg::*; ();

  logic s_systemClock;
  logic s_pllLocked;
  logic camPclk;
  logic camHsync;
  logic camVsync;
  pixelByte_t camData;
  logic camnReset;
  logic ciStart;
  ciId_t ciN;
  busWord_t ciValueA;
  busWord_t ciValueB;
  logic ciDone;
  busWord_t ciResult;
  logic requestBus;
  logic busGrant;
  logic busy;
  logic busError;
  logic beginTransaction;
  logic endTransaction;
  logic dataValid;
  logic readNotWrite;
  byteEnable_t byteEnables;
  burstSize_t burstSize;
  busWord_t addressData;

  logic [15:0] lfsrState;
  busWord_t memory [busWord_t];
  busWord_t expectedMem [busWord_t];
  busWord_t burstAddrs [$];
  pixelByte_t frameBytes [$];
  busWord_t burstAddress;
  int beatCount;
  int burstsDone;
  int beginsSeen;
  int stallsSeen;
  int grantWait;
  int abortIndex;
  int abortBeats;
  logic burstAborted;
  logic injectError;
  logic busyEnable;
  logic nextGrant;
  logic nextBusy;
  logic nextBusError;
  int vsyncCount;
  int errorCount;
  int testStartErrors;
  int testsPassed;
  int testsFailed;

  cameraCapture uut (.*);

  always #10 s_systemClock = ~s_systemClock;

  // galois lfsr, one step per bit.
  function automatic logic [7:0] randomBits(input int width);
    logic [7:0] value;
    int i;
    value = '0;
    for (i = 0; i < width; i++) begin
      value = {value[6:0], lfsrState[0]};
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
    end
    return value;
  endfunction

  function automatic logic busActive();
    return beginTransaction || endTransaction || dataValid || readNotWrite ||
           (|byteEnables) || (|burstSize) || (|addressData);
  endfunction

  task automatic reportError(input string message);
    $display("ERROR at %0t ns: %s", $time, message);
    errorCount++;
  endtask

  task automatic finishTest(input string name);
    if (errorCount == testStartErrors) begin
      testsPassed++;
      $display("%s: passed", name);
    end else begin
      testsFailed++;
      $display("%s: failed", name);
    end
    testStartErrors = errorCount;
  endtask

  // ends 2 ns after the n-th rising edge.
  task automatic nextCycles(input int n);
    repeat (n) @(posedge s_systemClock);
    #2;
  endtask

  task automatic customInstruction(input ciId_t n, input busWord_t a, input busWord_t b,
                                   output logic done, output busWord_t result);
    ciStart = 1'b1;
    ciN = n;
    ciValueA = a;
    ciValueB = b;
    @(negedge s_systemClock);
    done = ciDone;
    result = ciResult;
    nextCycles(1);
    ciStart = 1'b0;
    ciValueB = '0;
  endtask

  task automatic setBase(input busWord_t base);
    logic done;
    busWord_t result;
    customInstruction(`CAM_CI_ID, base, 32'd1, done, result);
    assert (done && result == '0)
      else reportError($sformatf("base write gave done %b result %h", done, result));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // camera pins
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic sendByte(input pixelByte_t value);
    camData = value;
    camPclk = 1'b0;
    nextCycles(4);
    camPclk = 1'b1;
    nextCycles(4);
  endtask

  // three junk bytes follow each line with hsync low.
  task automatic sendFrame(input int lines, input int lineBytes);
    pixelByte_t value;
    int line;
    int i;
    frameBytes.delete();
    camVsync = 1'b1;
    nextCycles(8);
    camVsync = 1'b0;
    nextCycles(8);
    vsyncCount++;
    for (line = 0; line < lines; line++) begin
      camHsync = 1'b1;
      for (i = 0; i < lineBytes; i++) begin
        value = randomBits(8);
        frameBytes.push_back(value);
        sendByte(value);
      end
      camHsync = 1'b0;
      for (i = 0; i < 3; i++) begin
        sendByte(randomBits(8));
      end
    end
  endtask

  // big-endian words from base, minus the skipped address range.
  task automatic addExpected(input busWord_t base, input busWord_t skipFrom,
                             input busWord_t skipTo);
    busWord_t addr;
    int k;
    for (k = 0; k < frameBytes.size() / 4; k++) begin
      addr = base + busWord_t'(4 * k);
      if (addr < skipFrom || addr >= skipTo) begin
        expectedMem[addr] = {frameBytes[4*k], frameBytes[4*k+1],
                             frameBytes[4*k+2], frameBytes[4*k+3]};
      end
    end
  endtask

  task automatic checkMemory();
    assert (memory.num() == expectedMem.num())
      else reportError($sformatf("memory holds %0d words, expected %0d",
                                 memory.num(), expectedMem.num()));
    foreach (expectedMem[a]) begin
      assert (memory.exists(a) && memory[a] == expectedMem[a])
        else reportError($sformatf("word at %h is %h, expected %h",
                                   a, memory[a], expectedMem[a]));
    end
  endtask

  task automatic waitBursts(input int target);
    int waited;
    waited = 0;
    while (burstsDone < target && waited < 3000) begin
      nextCycles(1);
      waited++;
    end
    if (burstsDone < target) begin
      $display("timeout: only %0d of %0d bursts ended", burstsDone, target);
      errorCount++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // bus slave model
  // ~~~~~~~~~~~~~~~~~~~~
  initial begin
    forever begin
      @(negedge s_systemClock);
      nextGrant = 1'b0;
      nextBusError = 1'b0;
      nextBusy = busyEnable && (randomBits(2) == 2'd0);
      if (beginTransaction) begin
        assert (burstSize == burstSize_t'(`BURST_WORDS - 1) && byteEnables == 4'hF &&
                !readNotWrite && !dataValid)
          else reportError($sformatf("bad address beat, size %0d enables %b",
                                     burstSize, byteEnables));
        burstAddress = addressData;
        burstAddrs.push_back(addressData);
        beatCount = 0;
        burstAborted = 1'b0;
        beginsSeen++;
      end
      if (dataValid && busError) begin
        burstAborted = 1'b1;
        abortIndex = burstAddrs.size() - 1;
        abortBeats = beatCount;
      end else if (dataValid && busy) begin
        stallsSeen++;
      end else if (dataValid) begin
        memory[burstAddress + busWord_t'(4 * beatCount)] = addressData;
        beatCount++;
        if (injectError && beatCount == 3) begin
          nextBusError = 1'b1;
          nextBusy = 1'b0;
          injectError = 1'b0;
        end
      end
      if (endTransaction) begin
        assert (burstAborted || beatCount == `BURST_WORDS)
          else reportError($sformatf("burst ended after %0d beats", beatCount));
        burstsDone++;
      end
      // grant after a random wait in the request phase.
      if (requestBus && !beginTransaction && !dataValid && !busGrant) begin
        if (grantWait == 0) begin
          nextGrant = 1'b1;
        end else begin
          grantWait--;
        end
      end
      if (busGrant) begin
        grantWait = randomBits(3);
      end
      @(posedge s_systemClock);
      #2;
      busGrant = nextGrant;
      busy = nextBusy;
      busError = nextBusError;
    end
  end

  initial begin
    logic done;
    busWord_t result;
    busWord_t abortAddr;
    int cycles;
    int target;
    lfsrState = 16'd67;
    s_systemClock = 1'b0;
    s_pllLocked = 1'b0;
    camPclk = 1'b0;
    camHsync = 1'b0;
    camVsync = 1'b0;
    camData = '0;
    // a matching read is held through reset.
    ciStart = 1'b1;
    ciN = `CAM_CI_ID;
    ciValueA = '0;
    ciValueB = '0;
    busGrant = 1'b0;
    busy = 1'b0;
    busError = 1'b0;
    burstsDone = 0;
    beginsSeen = 0;
    stallsSeen = 0;
    grantWait = 0;
    abortIndex = -1;
    abortBeats = 0;
    burstAborted = 1'b0;
    injectError = 1'b0;
    busyEnable = 1'b0;
    vsyncCount = 0;
    errorCount = 0;
    testStartErrors = 0;
    testsPassed = 0;
    testsFailed = 0;

    repeat (16) begin
      @(negedge s_systemClock);
      assert (!camnReset && !requestBus && !ciDone && !busActive())
        else reportError("output active before pll lock");
    end
    nextCycles(1);
    s_pllLocked = 1'b1;
    cycles = 0;
    while (!camnReset && cycles < 40) begin
      @(posedge s_systemClock);
      #1;
      cycles++;
      if (!camnReset) begin
        assert (!requestBus && !ciDone && !uut.push && !busActive())
          else reportError("output active during internal reset");
      end
    end
    #1;
    ciStart = 1'b0;
    ciN = '0;
    assert (cycles == 16)
      else reportError($sformatf("camnReset rose after %0d cycles", cycles));
    finishTest("reset");

    setBase(32'h0000_1000);
    target = burstsDone + 4;
    sendFrame(2, 64);
    addExpected(32'h0000_1000, '0, '0);
    waitBursts(target);
    checkMemory();
    finishTest("capture");

    busyEnable = 1'b1;
    setBase(32'h0000_4000);
    target = burstsDone + 3;
    sendFrame(1, 96);
    addExpected(32'h0000_4000, '0, '0);
    waitBursts(target);
    checkMemory();
    assert (stallsSeen > 0) else reportError("busy never stalled a data beat");
    assert (beginsSeen == burstsDone)
      else reportError($sformatf("%0d address beats, %0d ends", beginsSeen, burstsDone));
    finishTest("burst form under back-pressure");

    customInstruction(`CAM_CI_ID, '0, '0, done, result);
    assert (done && result == busWord_t'(vsyncCount))
      else reportError($sformatf("frame count read %h, expected %0d", result, vsyncCount));
    customInstruction(8'd5, 32'h0000_ffff, 32'd0, done, result);
    assert (!done && result == '0)
      else reportError($sformatf("foreign instruction gave done %b result %h", done, result));
    finishTest("custom instruction");

    setBase(32'h0000_8000);
    injectError = 1'b1;
    target = burstsDone + 2;
    sendFrame(1, 64);
    waitBursts(target);
    if (abortIndex >= 0 && abortIndex + 1 < burstAddrs.size()) begin
      abortAddr = burstAddrs[abortIndex];
      assert (burstAddrs[abortIndex + 1] == abortAddr + 32'd32)
        else reportError($sformatf("burst after abort at %h, aborted at %h",
                                   burstAddrs[abortIndex + 1], abortAddr));
      addExpected(32'h0000_8000, abortAddr + busWord_t'(4 * abortBeats),
                  abortAddr + 32'd32);
      checkMemory();
    end else begin
      $display("the injected bus error did not abort a burst");
      errorCount++;
    end
    finishTest("bus error");

    // earlier frames must survive this one.
    setBase(32'h0000_c000);
    target = burstsDone + 2;
    sendFrame(2, 32);
    addExpected(32'h0000_c000, '0, '0);
    waitBursts(target);
    checkMemory();
    finishTest("new frame");

    $display("tests passed %0d, failed %0d", testsPassed, testsFailed);
    if (testsFailed == 0 && errorCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+hw
hw/cameraPkg.sv
hw/pixelPacker.sv
hw/pixelFifo.sv
hw/burstWriter.sv
hw/cameraCapture.sv
bench/cameraCaptureTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
  --top-module cameraCaptureTb -f files.f -o simCamera > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/simCamera > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST OK" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
